/* mci_top.f */
logic/mci_wdt_pkg.sv
logic/mci_err_pkg.sv
logic/wdt_timer_if.sv
logic/err_status_if.sv
logic/wdt_timer.sv
logic/mci_wdt.sv
logic/mci_error_regs.sv
logic/mci_error_agg.sv
logic/mci_top.sv
verification/mci_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the mci_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mci_top_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
  -f mci_top.f \
  --top-module mci_top_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG_FILE"; then
  echo "Run passed, log in $LOG_FILE"
  exit 0
fi

echo "Run failed, log in $LOG_FILE"
exit 1

/* verification/mci_top_tb.sv */
// Testbench for mci_top with clock, reset, stimulus and reference models
// Concurrent assertions compare the DUT against the models
`timescale 1ns/1ps
`default_nettype none

module mci_top_tb
  import mci_wdt_pkg::*;
  import mci_err_pkg::*;
();

  localparam int ClkPeriod    = 8;
  localparam int MinPeriod    = 20;
  localparam int MaxPeriod    = 60;
  localparam int PetCount     = 8;
  localparam int StickyCycles = 60;
  localparam int AggCycles    = 80;
  // Worst case length of all tests in cycles including resets
  localparam int TestCycles   = (PetCount + 1) * MaxPeriod + 2 * (MaxPeriod + 1) +
                                StickyCycles + AggCycles + 64;

  logic           core_clk;
  logic           arst_n;
  logic           timer1_en, timer2_en, timer1_restart, timer2_restart;
  logic           t1_serviced, t2_serviced, t1_timeout, t2_timeout;
  wdt_count_t     t1_period, t2_period;
  logic           sram_ecc_unc, dmi_axi_collision, mbox0_ecc_unc, mbox1_ecc_unc;
  hw_fatal_t      fatal_clr, fatal_mask, hw_fatal, fatal_set;
  hw_non_fatal_t  non_fatal_clr, non_fatal_mask, hw_non_fatal, non_fatal_set;
  logic           fw_fatal_wr, fw_non_fatal_wr;
  fw_error_code_t fw_fatal_code, fw_non_fatal_code, fw_fatal_mask, fw_non_fatal_mask;
  agg_error_t     agg_fatal, agg_non_fatal, agg_fatal_mask, agg_non_fatal_mask;
  logic           all_fatal, all_non_fatal;

  // Reference model state
  int unsigned    t1_elapsed, t2_elapsed;
  logic           exp_t1_to, exp_t2_to, exp_t2_to_d, exp_nmi;
  logic [3:0]     t2_rise_hist;
  hw_fatal_t      exp_hw_fatal;
  hw_non_fatal_t  exp_hw_non_fatal;
  fw_error_code_t exp_fw_fatal, exp_fw_non_fatal;
  logic           cascade, t1_restart_m, t2_restart_m, t2_runs;
  logic           fatal_cond, non_fatal_cond;
  logic [1:0]     fatal_cond_d, non_fatal_cond_d;
  logic           in_reset_d = 1'b1;
  logic           agg_phase, seen_fatal, seen_non_fatal;
  int             value_errors;
  int             other_errors;
  string          test_name;

  mci_top dut_i (
    .core_clk_i                   (core_clk),
    .arst_n_i                     (arst_n),
    .timer1_en_i                  (timer1_en),
    .timer2_en_i                  (timer2_en),
    .timer1_restart_i             (timer1_restart),
    .timer2_restart_i             (timer2_restart),
    .t1_timeout_serviced_i        (t1_serviced),
    .t2_timeout_serviced_i        (t2_serviced),
    .t1_period_i                  (t1_period),
    .t2_period_i                  (t2_period),
    .t1_timeout_o                 (t1_timeout),
    .t2_timeout_o                 (t2_timeout),
    .mcu_sram_ecc_unc_i           (sram_ecc_unc),
    .mcu_sram_dmi_axi_collision_i (dmi_axi_collision),
    .mbox0_ecc_unc_i              (mbox0_ecc_unc),
    .mbox1_ecc_unc_i              (mbox1_ecc_unc),
    .hw_error_fatal_clr_i         (fatal_clr),
    .hw_error_non_fatal_clr_i     (non_fatal_clr),
    .fw_error_fatal_wr_i          (fw_fatal_wr),
    .fw_error_non_fatal_wr_i      (fw_non_fatal_wr),
    .fw_error_fatal_code_i        (fw_fatal_code),
    .fw_error_non_fatal_code_i    (fw_non_fatal_code),
    .hw_error_fatal_o             (hw_fatal),
    .hw_error_non_fatal_o         (hw_non_fatal),
    .hw_error_fatal_mask_i        (fatal_mask),
    .hw_error_non_fatal_mask_i    (non_fatal_mask),
    .fw_error_fatal_mask_i        (fw_fatal_mask),
    .fw_error_non_fatal_mask_i    (fw_non_fatal_mask),
    .agg_error_fatal_i            (agg_fatal),
    .agg_error_non_fatal_i        (agg_non_fatal),
    .agg_error_fatal_mask_i       (agg_fatal_mask),
    .agg_error_non_fatal_mask_i   (agg_non_fatal_mask),
    .all_error_fatal_o            (all_fatal),
    .all_error_non_fatal_o        (all_non_fatal)
  );

  initial begin
    core_clk = 1'b0;
    forever #(ClkPeriod / 2) core_clk = ~core_clk;
  end

  //////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////

  // Pets count only before expiry, services only after it
  assign cascade      = timer1_en && !timer2_en;
  assign t1_restart_m = (timer1_restart && !exp_t1_to) || (t1_serviced && exp_t1_to);
  assign t2_restart_m = (timer2_restart && !exp_t2_to) || (t2_serviced && exp_t2_to) ||
                        (cascade && t1_serviced && exp_t1_to);
  assign t2_runs      = cascade ? exp_t1_to : timer2_en;

  always_comb begin
    fatal_set                              = '0;
    fatal_set[HwFatalNmiPin]               = exp_nmi;
    fatal_set[HwFatalSramEccUnc]           = sram_ecc_unc;
    fatal_set[HwFatalDmiAxiCollision]      = dmi_axi_collision;
    non_fatal_set                          = '0;
    non_fatal_set[HwNonFatalMbox0EccUnc]   = mbox0_ecc_unc;
    non_fatal_set[HwNonFatalMbox1EccUnc]   = mbox1_ecc_unc;
  end

  // Unmasked hardware, firmware or external source
  assign fatal_cond = |(exp_hw_fatal & ~fatal_mask) | |(exp_fw_fatal & ~fw_fatal_mask) |
                      |(agg_fatal & ~agg_fatal_mask);
  assign non_fatal_cond = |(exp_hw_non_fatal & ~non_fatal_mask) |
                          |(exp_fw_non_fatal & ~fw_non_fatal_mask) |
                          |(agg_non_fatal & ~agg_non_fatal_mask);

  always @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      t1_elapsed       <= 0;
      t2_elapsed       <= 0;
      exp_t1_to        <= 1'b0;
      exp_t2_to        <= 1'b0;
      exp_t2_to_d      <= 1'b0;
      exp_nmi          <= 1'b0;
      t2_rise_hist     <= '0;
      exp_hw_fatal     <= '0;
      exp_hw_non_fatal <= '0;
      exp_fw_fatal     <= '0;
      exp_fw_non_fatal <= '0;
      fatal_cond_d     <= '0;
      non_fatal_cond_d <= '0;
    end else begin
      // A timer expires period+1 edges after its last restart
      if (t1_restart_m) begin
        t1_elapsed <= 0;
        exp_t1_to  <= 1'b0;
      end else if (timer1_en && !exp_t1_to) begin
        t1_elapsed <= t1_elapsed + 1;
        exp_t1_to  <= (t1_elapsed + 1 > t1_period);
      end
      if (t2_restart_m) begin
        t2_elapsed <= 0;
        exp_t2_to  <= 1'b0;
      end else if (t2_runs && !exp_t2_to) begin
        t2_elapsed <= t2_elapsed + 1;
        exp_t2_to  <= (t2_elapsed + 1 > t2_period);
      end
      exp_t2_to_d  <= exp_t2_to;
      exp_nmi      <= exp_t2_to && !exp_t2_to_d;
      t2_rise_hist <= {t2_rise_hist[2:0], exp_t2_to && !exp_t2_to_d};
      // A new event beats a clear on the sticky bits
      for (int b = 0; b < HwFatalCount; b++) begin
        if (fatal_set[b])
          exp_hw_fatal[b] <= 1'b1;
        else if (fatal_clr[b])
          exp_hw_fatal[b] <= 1'b0;
      end
      for (int b = 0; b < HwNonFatalCount; b++) begin
        if (non_fatal_set[b])
          exp_hw_non_fatal[b] <= 1'b1;
        else if (non_fatal_clr[b])
          exp_hw_non_fatal[b] <= 1'b0;
      end
      if (fw_fatal_wr)
        exp_fw_fatal <= fw_fatal_code;
      if (fw_non_fatal_wr)
        exp_fw_non_fatal <= fw_non_fatal_code;
      fatal_cond_d     <= {fatal_cond_d[0], fatal_cond};
      non_fatal_cond_d <= {non_fatal_cond_d[0], non_fatal_cond};
    end
  end

  always @(posedge core_clk) begin
    in_reset_d <= !arst_n;
    if (!agg_phase) begin
      seen_fatal     <= 1'b0;
      seen_non_fatal <= 1'b0;
    end else begin
      seen_fatal     <= seen_fatal || all_fatal;
      seen_non_fatal <= seen_non_fatal || all_non_fatal;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string check, input logic [63:0] expected,
                                 input logic [63:0] actual);
    value_errors++;
    $display("CHECK FAILED at %0t test %s, %s: expected %0h, actual %0h",
             $time, test_name, check, expected, actual);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("ERROR at %0t test %s: %s", $time, test_name, what);
  endtask

  reset_values_a: assert property (@(posedge core_clk)
    (!arst_n || in_reset_d) |-> {t1_timeout, t2_timeout, hw_fatal, hw_non_fatal,
                                 all_fatal, all_non_fatal} == '0)
    else report_mismatch("reset_outputs", 64'd0, 64'($sampled({t1_timeout, t2_timeout,
                         hw_fatal, hw_non_fatal, all_fatal, all_non_fatal})));

  t1_timeout_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    t1_timeout == exp_t1_to)
    else report_mismatch("t1_timeout", 64'($sampled(exp_t1_to)), 64'($sampled(t1_timeout)));

  t2_timeout_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    t2_timeout == exp_t2_to)
    else report_mismatch("t2_timeout", 64'($sampled(exp_t2_to)), 64'($sampled(t2_timeout)));

  hw_fatal_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    hw_fatal == exp_hw_fatal)
    else report_mismatch("hw_error_fatal", 64'($sampled(exp_hw_fatal)),
                         64'($sampled(hw_fatal)));

  hw_non_fatal_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    hw_non_fatal == exp_hw_non_fatal)
    else report_mismatch("hw_error_non_fatal", 64'($sampled(exp_hw_non_fatal)),
                         64'($sampled(hw_non_fatal)));

  // Output follows the combined condition two edges later
  all_fatal_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    all_fatal == fatal_cond_d[1])
    else report_mismatch("all_error_fatal", 64'($sampled(fatal_cond_d[1])),
                         64'($sampled(all_fatal)));

  all_non_fatal_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    all_non_fatal == non_fatal_cond_d[1])
    else report_mismatch("all_error_non_fatal", 64'($sampled(non_fatal_cond_d[1])),
                         64'($sampled(all_non_fatal)));

  // Timer 2 expiry reaches the fatal output after 4 cycles
  nmi_to_fatal_a: assert property (@(posedge core_clk) disable iff (!arst_n)
    t2_rise_hist[3] && !fatal_mask[HwFatalNmiPin] |-> all_fatal)
    else report_mismatch("nmi_to_all_fatal", 64'd1, 64'($sampled(all_fatal)));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic clear_inputs();
    {timer1_en, timer2_en, timer1_restart, timer2_restart} = '0;
    {t1_serviced, t2_serviced} = '0;
    {t1_period, t2_period} = '0;
    {sram_ecc_unc, dmi_axi_collision, mbox0_ecc_unc, mbox1_ecc_unc} = '0;
    {fatal_clr, non_fatal_clr, fatal_mask, non_fatal_mask} = '0;
    {fw_fatal_wr, fw_non_fatal_wr, fw_fatal_code, fw_non_fatal_code} = '0;
    {fw_fatal_mask, fw_non_fatal_mask} = '0;
    {agg_fatal, agg_non_fatal, agg_fatal_mask, agg_non_fatal_mask} = '0;
  endtask

  task automatic apply_reset();
    @(negedge core_clk);
    arst_n = 1'b0;
    repeat (3) @(negedge core_clk);
    arst_n = 1'b1;
  endtask

  task automatic pick_periods();
    t1_period = MinPeriod + $urandom % (MaxPeriod - MinPeriod + 1);
    t2_period = MinPeriod + $urandom % (MaxPeriod - MinPeriod + 1);
  endtask

  // Gaps stay below the period so the timer never expires while petted
  task automatic pet_randomly(input bit second);
    int unsigned period;
    int unsigned gap;
    period = second ? t2_period : t1_period;
    repeat (PetCount) begin
      gap = $urandom % (period - 1);
      repeat (gap) @(negedge core_clk);
      if (second)
        timer2_restart = 1'b1;
      else
        timer1_restart = 1'b1;
      @(negedge core_clk);
      if (second)
        timer2_restart = 1'b0;
      else
        timer1_restart = 1'b0;
    end
  endtask

  task automatic run_independent();
    test_name = "independent";
    clear_inputs();
    pick_periods();
    timer1_en = 1'b1;
    timer2_en = 1'b1;
    apply_reset();
    fork
      pet_randomly(1'b0);
      pet_randomly(1'b1);
    join
    while (!(t1_timeout && t2_timeout)) @(negedge core_clk);
    repeat (2) @(negedge core_clk);
  endtask

  task automatic run_cascade();
    test_name = "cascade";
    clear_inputs();
    pick_periods();
    timer1_en = 1'b1;
    apply_reset();
    while (!all_fatal) @(negedge core_clk);
    t1_serviced = 1'b1;
    @(negedge core_clk);
    t1_serviced = 1'b0;
    repeat (4) @(negedge core_clk);
  endtask

  task automatic run_sticky();
    test_name = "sticky";
    clear_inputs();
    apply_reset();
    repeat (StickyCycles) begin
      sram_ecc_unc      = ($urandom % 4) == 0;
      dmi_axi_collision = ($urandom % 4) == 0;
      mbox0_ecc_unc     = ($urandom % 4) == 0;
      mbox1_ecc_unc     = ($urandom % 4) == 0;
      fatal_clr         = (($urandom % 3) == 0) ? hw_fatal_t'($urandom) : '0;
      non_fatal_clr     = (($urandom % 3) == 0) ? hw_non_fatal_t'($urandom) : '0;
      @(negedge core_clk);
    end
    clear_inputs();
    fatal_clr     = '1;
    non_fatal_clr = '1;
    @(negedge core_clk);
    clear_inputs();
    @(negedge core_clk);
  endtask

  task automatic run_aggregation();
    test_name = "aggregation";
    clear_inputs();
    apply_reset();
    agg_phase = 1'b1;
    for (int i = 0; i < AggCycles; i++) begin
      // Sparse sources against dense masks
      agg_fatal          = agg_error_t'($urandom & $urandom & $urandom);
      agg_non_fatal      = agg_error_t'($urandom & $urandom & $urandom);
      agg_fatal_mask     = agg_error_t'($urandom | $urandom);
      agg_non_fatal_mask = agg_error_t'($urandom | $urandom);
      fatal_mask         = hw_fatal_t'($urandom);
      non_fatal_mask     = hw_non_fatal_t'($urandom);
      fw_fatal_mask      = $urandom | $urandom;
      fw_non_fatal_mask  = $urandom | $urandom;
      fw_fatal_wr        = ($urandom % 4) == 0;
      fw_non_fatal_wr    = ($urandom % 4) == 0;
      fw_fatal_code      = ($urandom % 2) ? '0 : ($urandom & $urandom);
      fw_non_fatal_code  = ($urandom % 2) ? '0 : ($urandom & $urandom);
      sram_ecc_unc       = ($urandom % 8) == 0;
      mbox1_ecc_unc      = ($urandom % 8) == 0;
      // Last stretch with every source masked
      if (i >= AggCycles - 16) begin
        {agg_fatal_mask, agg_non_fatal_mask, fatal_mask, non_fatal_mask} = '1;
        {fw_fatal_mask, fw_non_fatal_mask} = '1;
      end
      @(negedge core_clk);
    end
    clear_inputs();
    repeat (3) @(negedge core_clk);
    assert (seen_fatal && seen_non_fatal)
      else report_failure("aggregate outputs never went high during the test");
    agg_phase = 1'b0;
  endtask

  initial begin
    void'($urandom(63242));
    value_errors = 0;
    other_errors = 0;
    agg_phase    = 1'b0;
    test_name    = "reset";
    arst_n       = 1'b0;
    clear_inputs();
    run_independent();
    run_cascade();
    run_sticky();
    run_aggregation();
    repeat (2) @(negedge core_clk);
    $display("Done: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog with twice the worst case test length
  initial begin
    #(2 * TestCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, a test is stuck", 2 * TestCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/mci_top.sv */
// Management controller top level with the watchdog, error registers and aggregator
`timescale 1ns/1ps
`default_nettype none

module mci_top
  import mci_wdt_pkg::*;
  import mci_err_pkg::*;
(
  input  logic           core_clk_i,
  input  logic           arst_n_i,
  // Watchdog
  input  logic           timer1_en_i,
  input  logic           timer2_en_i,
  input  logic           timer1_restart_i,
  input  logic           timer2_restart_i,
  input  logic           t1_timeout_serviced_i,
  input  logic           t2_timeout_serviced_i,
  input  wdt_count_t     t1_period_i,
  input  wdt_count_t     t2_period_i,
  output logic           t1_timeout_o,
  output logic           t2_timeout_o,
  // Hardware and firmware error sources
  input  logic           mcu_sram_ecc_unc_i,
  input  logic           mcu_sram_dmi_axi_collision_i,
  input  logic           mbox0_ecc_unc_i,
  input  logic           mbox1_ecc_unc_i,
  input  hw_fatal_t      hw_error_fatal_clr_i,
  input  hw_non_fatal_t  hw_error_non_fatal_clr_i,
  input  logic           fw_error_fatal_wr_i,
  input  logic           fw_error_non_fatal_wr_i,
  input  fw_error_code_t fw_error_fatal_code_i,
  input  fw_error_code_t fw_error_non_fatal_code_i,
  output hw_fatal_t      hw_error_fatal_o,
  output hw_non_fatal_t  hw_error_non_fatal_o,
  // Aggregation
  input  hw_fatal_t      hw_error_fatal_mask_i,
  input  hw_non_fatal_t  hw_error_non_fatal_mask_i,
  input  fw_error_code_t fw_error_fatal_mask_i,
  input  fw_error_code_t fw_error_non_fatal_mask_i,
  input  agg_error_t     agg_error_fatal_i,
  input  agg_error_t     agg_error_non_fatal_i,
  input  agg_error_t     agg_error_fatal_mask_i,
  input  agg_error_t     agg_error_non_fatal_mask_i,
  output logic           all_error_fatal_o,
  output logic           all_error_non_fatal_o
);

  logic nmi;

  err_status_if status_if ();

  mci_wdt u_wdt (
    .core_clk_i            (core_clk_i),
    .arst_n_i              (arst_n_i),
    .timer1_en_i           (timer1_en_i),
    .timer2_en_i           (timer2_en_i),
    .timer1_restart_i      (timer1_restart_i),
    .timer2_restart_i      (timer2_restart_i),
    .t1_timeout_serviced_i (t1_timeout_serviced_i),
    .t2_timeout_serviced_i (t2_timeout_serviced_i),
    .t1_period_i           (t1_period_i),
    .t2_period_i           (t2_period_i),
    .t1_timeout_o          (t1_timeout_o),
    .t2_timeout_o          (t2_timeout_o),
    .nmi_o                 (nmi)
  );

  mci_error_regs u_error_regs (
    .core_clk_i                   (core_clk_i),
    .arst_n_i                     (arst_n_i),
    .nmi_i                        (nmi),
    .mcu_sram_ecc_unc_i           (mcu_sram_ecc_unc_i),
    .mcu_sram_dmi_axi_collision_i (mcu_sram_dmi_axi_collision_i),
    .mbox0_ecc_unc_i              (mbox0_ecc_unc_i),
    .mbox1_ecc_unc_i              (mbox1_ecc_unc_i),
    .hw_error_fatal_clr_i         (hw_error_fatal_clr_i),
    .hw_error_non_fatal_clr_i     (hw_error_non_fatal_clr_i),
    .fw_error_fatal_wr_i          (fw_error_fatal_wr_i),
    .fw_error_non_fatal_wr_i      (fw_error_non_fatal_wr_i),
    .fw_error_fatal_code_i        (fw_error_fatal_code_i),
    .fw_error_non_fatal_code_i    (fw_error_non_fatal_code_i),
    .status                       (status_if.src)
  );

  mci_error_agg u_error_agg (
    .core_clk_i                 (core_clk_i),
    .arst_n_i                   (arst_n_i),
    .status                     (status_if.sink),
    .hw_error_fatal_mask_i      (hw_error_fatal_mask_i),
    .hw_error_non_fatal_mask_i  (hw_error_non_fatal_mask_i),
    .fw_error_fatal_mask_i      (fw_error_fatal_mask_i),
    .fw_error_non_fatal_mask_i  (fw_error_non_fatal_mask_i),
    .agg_error_fatal_i          (agg_error_fatal_i),
    .agg_error_non_fatal_i      (agg_error_non_fatal_i),
    .agg_error_fatal_mask_i     (agg_error_fatal_mask_i),
    .agg_error_non_fatal_mask_i (agg_error_non_fatal_mask_i),
    .all_error_fatal_o          (all_error_fatal_o),
    .all_error_non_fatal_o      (all_error_non_fatal_o)
  );

  // Sticky status is visible outside for polling
  assign hw_error_fatal_o     = status_if.hw_fatal;
  assign hw_error_non_fatal_o = status_if.hw_non_fatal;

endmodule

`default_nettype wire

/* logic/mci_error_agg.sv */
// Error masking and two-stage registered combination into fatal and non-fatal
`timescale 1ns/1ps
`default_nettype none

module mci_error_agg
  import mci_err_pkg::*;
(
  input  logic           core_clk_i,
  input  logic           arst_n_i,
  err_status_if.sink     status,
  input  hw_fatal_t      hw_error_fatal_mask_i,
  input  hw_non_fatal_t  hw_error_non_fatal_mask_i,
  input  fw_error_code_t fw_error_fatal_mask_i,
  input  fw_error_code_t fw_error_non_fatal_mask_i,
  input  agg_error_t     agg_error_fatal_i,
  input  agg_error_t     agg_error_non_fatal_i,
  input  agg_error_t     agg_error_fatal_mask_i,
  input  agg_error_t     agg_error_non_fatal_mask_i,
  output logic           all_error_fatal_o,
  output logic           all_error_non_fatal_o
);

  logic fatal_cond;
  logic non_fatal_cond;
  logic fatal_cond_q;
  logic non_fatal_cond_q;

  // A set mask bit hides its source
  assign fatal_cond = |(status.hw_fatal & ~hw_error_fatal_mask_i) |
                      |(status.fw_fatal & ~fw_error_fatal_mask_i) |
                      |(agg_error_fatal_i & ~agg_error_fatal_mask_i);

  assign non_fatal_cond = |(status.hw_non_fatal & ~hw_error_non_fatal_mask_i) |
                          |(status.fw_non_fatal & ~fw_error_non_fatal_mask_i) |
                          |(agg_error_non_fatal_i & ~agg_error_non_fatal_mask_i);

  //////////////////////////////////////////////////
  // Output pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fatal_cond_q          <= 1'b0;
      non_fatal_cond_q      <= 1'b0;
      all_error_fatal_o     <= 1'b0;
      all_error_non_fatal_o <= 1'b0;
    end else begin
      fatal_cond_q          <= fatal_cond;
      non_fatal_cond_q      <= non_fatal_cond;
      all_error_fatal_o     <= fatal_cond_q;
      all_error_non_fatal_o <= non_fatal_cond_q;
    end
  end

  fatal_rise_has_cause_a: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    $rose(all_error_fatal_o) |-> $past(fatal_cond, 2)
  ) else $error("mci_error_agg: all_error_fatal rose without an unmasked source");

  non_fatal_rise_has_cause_a: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    $rose(all_error_non_fatal_o) |-> $past(non_fatal_cond, 2)
  ) else $error("mci_error_agg: all_error_non_fatal rose without an unmasked source");

endmodule

`default_nettype wire

/* logic/mci_error_regs.sv */
// Sticky hardware error bits with W1C and the firmware error code registers
`timescale 1ns/1ps
`default_nettype none

module mci_error_regs
  import mci_err_pkg::*;
(
  input  logic           core_clk_i,
  input  logic           arst_n_i,
  input  logic           nmi_i,
  input  logic           mcu_sram_ecc_unc_i,
  input  logic           mcu_sram_dmi_axi_collision_i,
  input  logic           mbox0_ecc_unc_i,
  input  logic           mbox1_ecc_unc_i,
  input  hw_fatal_t      hw_error_fatal_clr_i,
  input  hw_non_fatal_t  hw_error_non_fatal_clr_i,
  input  logic           fw_error_fatal_wr_i,
  input  logic           fw_error_non_fatal_wr_i,
  input  fw_error_code_t fw_error_fatal_code_i,
  input  fw_error_code_t fw_error_non_fatal_code_i,
  err_status_if.src      status
);

  hw_fatal_t      hw_fatal_set;
  hw_fatal_t      hw_fatal_q;
  hw_non_fatal_t  hw_non_fatal_set;
  hw_non_fatal_t  hw_non_fatal_q;
  fw_error_code_t fw_fatal_q;
  fw_error_code_t fw_non_fatal_q;

  //////////////////////////////////////////////////
  // Hardware error set vectors
  //////////////////////////////////////////////////

  always_comb begin
    hw_fatal_set                         = '0;
    hw_fatal_set[HwFatalNmiPin]          = nmi_i;
    hw_fatal_set[HwFatalSramEccUnc]      = mcu_sram_ecc_unc_i;
    hw_fatal_set[HwFatalDmiAxiCollision] = mcu_sram_dmi_axi_collision_i;

    hw_non_fatal_set                        = '0;
    hw_non_fatal_set[HwNonFatalMbox0EccUnc] = mbox0_ecc_unc_i;
    hw_non_fatal_set[HwNonFatalMbox1EccUnc] = mbox1_ecc_unc_i;
  end

  // Sticky HW_ERROR_FATAL and HW_ERROR_NON_FATAL where a new event beats a W1C
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hw_fatal_q     <= '0;
      hw_non_fatal_q <= '0;
    end else begin
      hw_fatal_q     <= (hw_fatal_q & ~hw_error_fatal_clr_i) | hw_fatal_set;
      hw_non_fatal_q <= (hw_non_fatal_q & ~hw_error_non_fatal_clr_i) | hw_non_fatal_set;
    end
  end

  //////////////////////////////////////////////////
  // Firmware error codes
  //////////////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fw_fatal_q     <= '0;
      fw_non_fatal_q <= '0;
    end else begin
      if (fw_error_fatal_wr_i) begin
        fw_fatal_q <= fw_error_fatal_code_i;
      end
      if (fw_error_non_fatal_wr_i) begin
        fw_non_fatal_q <= fw_error_non_fatal_code_i;
      end
    end
  end

  assign status.hw_fatal     = hw_fatal_q;
  assign status.hw_non_fatal = hw_non_fatal_q;
  assign status.fw_fatal     = fw_fatal_q;
  assign status.fw_non_fatal = fw_non_fatal_q;

  hw_error_set_a: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    (|hw_fatal_set || |hw_non_fatal_set) |=>
      ((hw_fatal_q & $past(hw_fatal_set)) == $past(hw_fatal_set)) &&
      ((hw_non_fatal_q & $past(hw_non_fatal_set)) == $past(hw_non_fatal_set))
  ) else $error("mci_error_regs: error source pulse did not set its sticky bit");

endmodule

`default_nettype wire

/* logic/mci_wdt.sv */
// Two-stage watchdog with mode decode, cascade sequencing and NMI generation
`timescale 1ns/1ps
`default_nettype none

module mci_wdt
  import mci_wdt_pkg::*;
(
  input  logic       core_clk_i,
  input  logic       arst_n_i,
  input  logic       timer1_en_i,
  input  logic       timer2_en_i,
  input  logic       timer1_restart_i,
  input  logic       timer2_restart_i,
  input  logic       t1_timeout_serviced_i,
  input  logic       t2_timeout_serviced_i,
  input  wdt_count_t t1_period_i,
  input  wdt_count_t t2_period_i,
  output logic       t1_timeout_o,
  output logic       t2_timeout_o,
  output logic       nmi_o
);

  wdt_timer_if t1_if ();
  wdt_timer_if t2_if ();

  wdt_mode_e wdt_mode;
  logic      t1_service;
  logic      t2_service;
  logic      t2_run;
  logic      t2_timeout_q;
  logic      nmi_q;

  always_comb begin
    case ({timer1_en_i, timer2_en_i})
      2'b00:   wdt_mode = WdtDisabled;
      2'b10:   wdt_mode = WdtCascade;
      default: wdt_mode = WdtIndependent;
    endcase
  end

  // A service only counts against a pending timeout
  assign t1_service = t1_timeout_serviced_i && t1_if.timeout;
  assign t2_service = t2_timeout_serviced_i && t2_if.timeout;

  //////////////////////////////////////////////////
  // Timer 1
  //////////////////////////////////////////////////

  assign t1_if.run     = timer1_en_i;
  assign t1_if.period  = t1_period_i;
  assign t1_if.restart = (timer1_restart_i && !t1_if.timeout) || t1_service;

  wdt_timer u_timer1 (
    .core_clk_i (core_clk_i),
    .arst_n_i   (arst_n_i),
    .tmr        (t1_if.timer)
  );

  //////////////////////////////////////////////////
  // Timer 2
  //////////////////////////////////////////////////

  // In cascade mode timer 2 only counts while timer 1 sits expired
  always_comb begin
    case (wdt_mode)
      WdtCascade:     t2_run = t1_if.timeout;
      WdtIndependent: t2_run = timer2_en_i;
      default:        t2_run = 1'b0;
    endcase
  end

  assign t2_if.run     = t2_run;
  assign t2_if.period  = t2_period_i;
  assign t2_if.restart = (timer2_restart_i && !t2_if.timeout) || t2_service ||
                         ((wdt_mode == WdtCascade) && t1_service);

  wdt_timer u_timer2 (
    .core_clk_i (core_clk_i),
    .arst_n_i   (arst_n_i),
    .tmr        (t2_if.timer)
  );

  // NMI is a one-cycle pulse on the rising edge of the timer 2 timeout
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      t2_timeout_q <= 1'b0;
      nmi_q        <= 1'b0;
    end else begin
      t2_timeout_q <= t2_if.timeout;
      nmi_q        <= t2_if.timeout && !t2_timeout_q;
    end
  end

  assign t1_timeout_o = t1_if.timeout;
  assign t2_timeout_o = t2_if.timeout;
  assign nmi_o        = nmi_q;

  cascade_t2_after_t1_a: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    $rose(t2_if.timeout) && $past(wdt_mode == WdtCascade) |-> $past(t1_if.timeout)
  ) else $error("mci_wdt: cascade timer 2 expired without timer 1 timeout");

endmodule

`default_nettype wire

/* logic/wdt_timer.sv */
// Single watchdog counter with restart, period compare and sticky timeout
`timescale 1ns/1ps
`default_nettype none

module wdt_timer
  import mci_wdt_pkg::*;
(
  input  logic       core_clk_i,
  input  logic       arst_n_i,
  wdt_timer_if.timer tmr
);

  wdt_count_t count_q;
  logic       timeout_q;
  logic       expire;

  // Reaching the period while running expires the timer
  assign expire = tmr.run && !timeout_q && (count_q == tmr.period);

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q   <= '0;
      timeout_q <= 1'b0;
    end else if (tmr.restart) begin
      // Restart from a pet or service wins over counting
      count_q   <= '0;
      timeout_q <= 1'b0;
    end else if (expire) begin
      // Count freezes at the period once expired
      timeout_q <= 1'b1;
    end else if (tmr.run && !timeout_q) begin
      count_q <= count_q + wdt_count_t'(1);
    end
  end

  assign tmr.count   = count_q;
  assign tmr.timeout = timeout_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  restart_clears_count_a: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    tmr.restart |=> (tmr.count == '0) && !tmr.timeout
  ) else $error("wdt_timer: count or timeout not cleared after restart");

endmodule

`default_nettype wire

/* logic/err_status_if.sv */
// Sticky error state passed from the error registers to the aggregator
`timescale 1ns/1ps
`default_nettype none

interface err_status_if
  import mci_err_pkg::*;
();

  hw_fatal_t      hw_fatal;
  hw_non_fatal_t  hw_non_fatal;
  fw_error_code_t fw_fatal;
  fw_error_code_t fw_non_fatal;

  modport src (
    output hw_fatal,
    output hw_non_fatal,
    output fw_fatal,
    output fw_non_fatal
  );

  modport sink (
    input hw_fatal,
    input hw_non_fatal,
    input fw_fatal,
    input fw_non_fatal
  );

endinterface

`default_nettype wire

/* logic/wdt_timer_if.sv */
// Link between the watchdog controller and one watchdog timer
`timescale 1ns/1ps
`default_nettype none

interface wdt_timer_if
  import mci_wdt_pkg::*;
();

  logic       run;
  logic       restart;
  wdt_count_t period;
  wdt_count_t count;
  logic       timeout;

  // Controller side
  modport ctrl (
    output run,
    output restart,
    output period,
    input  count,
    input  timeout
  );

  // Counter side
  modport timer (
    input  run,
    input  restart,
    input  period,
    output count,
    output timeout
  );

endinterface

`default_nettype wire

/* logic/mci_err_pkg.sv */
// Error vector types, hardware error bit indices and source counts
`default_nettype none

package mci_err_pkg;

  //////////////////////////////////////////////////
  // Hardware fatal group
  //////////////////////////////////////////////////

  localparam int unsigned HwFatalCount = 3;

  localparam int unsigned HwFatalNmiPin          = 0;
  localparam int unsigned HwFatalSramEccUnc      = 1;
  localparam int unsigned HwFatalDmiAxiCollision = 2;

  //////////////////////////////////////////////////
  // Hardware non-fatal group
  //////////////////////////////////////////////////

  localparam int unsigned HwNonFatalCount = 2;

  localparam int unsigned HwNonFatalMbox0EccUnc = 0;
  localparam int unsigned HwNonFatalMbox1EccUnc = 1;

  //////////////////////////////////////////////////
  // External sources and firmware codes
  //////////////////////////////////////////////////

  // Aggregated error inputs from the rest of the subsystem
  localparam int unsigned AggSrcCount = 8;

  localparam int unsigned FwErrorWidth = 32;

  typedef logic [HwFatalCount-1:0]    hw_fatal_t;
  typedef logic [HwNonFatalCount-1:0] hw_non_fatal_t;
  typedef logic [AggSrcCount-1:0]     agg_error_t;
  typedef logic [FwErrorWidth-1:0]    fw_error_code_t;

endpackage

`default_nettype wire

/* logic/mci_wdt_pkg.sv */
// Watchdog widths, the timer count type and the watchdog mode encoding
`default_nettype none

package mci_wdt_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Timer count and period share one width
  localparam int unsigned WdtCountWidth = 32;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [WdtCountWidth-1:0] wdt_count_t;

  // Decoded from the two timer enables
  //   neither enabled     -> disabled
  //   only timer 1        -> cascade with timer 2 waiting for timer 1 expiry
  //   timer 2 enabled     -> independent timers
  typedef enum logic [1:0] {
    WdtDisabled    = 2'd0,
    WdtCascade     = 2'd1,
    WdtIndependent = 2'd2
  } wdt_mode_e;

endpackage

`default_nettype wire
